/* src/id_remap_pkg.sv */
// ID remap shared definitions.
// Widths, limits and vector types used by the read and write remap paths.
`default_nettype none

package id_remap_pkg;

  // Slave-side IDs are wide and sparsely used.
  localparam int unsigned SLV_ID_WIDTH = 8;

  // Number of table entries per direction.
  // This is also the number of distinct slave IDs that can be in flight.
  localparam int unsigned MAX_UNIQ_IDS = 4;

  // In-flight limit for any single slave ID.
  localparam int unsigned MAX_TXNS_PER_ID = 3;

  // Table index width, derived from the entry count.
  localparam int unsigned IDX_WIDTH = $clog2(MAX_UNIQ_IDS);

  // Master-side IDs are the table index, zero-extended to this width.
  localparam int unsigned MST_ID_WIDTH = 3;

  // Counter must be able to hold MAX_TXNS_PER_ID itself.
  localparam int unsigned CNT_WIDTH = $clog2(MAX_TXNS_PER_ID + 1);

  // Payload widths of the forwarded channels.
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned LEN_WIDTH  = 8;

  typedef logic [SLV_ID_WIDTH-1:0] slv_id_t;
  typedef logic [MST_ID_WIDTH-1:0] mst_id_t;
  typedef logic [IDX_WIDTH-1:0]    idx_t;
  typedef logic [CNT_WIDTH-1:0]    cnt_t;
  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [DATA_WIDTH-1:0]   data_t;
  typedef logic [LEN_WIDTH-1:0]    len_t;
  typedef logic [1:0]              resp_t;

endpackage

`default_nettype wire

/* src/remap_table_if.sv */
// Remap table lookup and push channel.
// Connects one address-channel controller to the remap table of its direction.
`timescale 1ns/1ps
`default_nettype none

interface remap_table_if;
  import id_remap_pkg::*;

  // Lookup of the pending request, answered combinationally by the table.
  slv_id_t lookup_id;
  logic    exists;
  idx_t    exists_idx;
  logic    exists_full;

  // Lowest free entry and the all-entries-busy flag.
  logic    full;
  idx_t    free_idx;

  // One-cycle push pulse; the entry count rises at the next clock edge.
  logic    push;
  slv_id_t push_slv_id;
  idx_t    push_idx;

  // Controller side.
  modport ctrl (
    output lookup_id, push, push_slv_id, push_idx,
    input  exists, exists_idx, exists_full, full, free_idx
  );

  // Table side.
  modport tbl (
    input  lookup_id, push, push_slv_id, push_idx,
    output exists, exists_idx, exists_full, full, free_idx
  );

endinterface

`default_nettype wire

/* src/id_remap_table.sv */
// ID remap table.
// Tracks which slave ID owns each master ID and how many of its transactions are in flight.
`timescale 1ns/1ps
`default_nettype none

module id_remap_table (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  remap_table_if.tbl            lkp,
  input  logic                  pop_i,
  input  id_remap_pkg::idx_t    pop_idx_i,
  output id_remap_pkg::slv_id_t pop_slv_id_o
);
  import id_remap_pkg::*;

  // One entry per master ID.
  // An entry is free when its count is zero; its stored ID is then meaningless.
  slv_id_t id_q  [MAX_UNIQ_IDS];
  cnt_t    cnt_q [MAX_UNIQ_IDS];

  logic [MAX_UNIQ_IDS-1:0] free_vec;
  logic [MAX_UNIQ_IDS-1:0] match_vec;
  logic [MAX_UNIQ_IDS-1:0] push_hit;
  logic [MAX_UNIQ_IDS-1:0] pop_hit;

  idx_t free_idx;
  idx_t match_idx;

  // Per-entry status and decoded push/pop targets.
  for (genvar i = 0; i < MAX_UNIQ_IDS; i++) begin : gen_entry
    assign free_vec[i]  = (cnt_q[i] == '0);
    assign match_vec[i] = (cnt_q[i] != '0) && (id_q[i] == lkp.lookup_id);
    assign push_hit[i]  = lkp.push && (lkp.push_idx == idx_t'(i));
    assign pop_hit[i]   = pop_i && (pop_idx_i == idx_t'(i));
  end

  // Lowest free entry.
  // Scanning from the top down lets the lowest hit overwrite the others.
  always_comb begin
    free_idx = '0;
    for (int i = MAX_UNIQ_IDS - 1; i >= 0; i--) begin
      if (free_vec[i]) begin
        free_idx = idx_t'(i);
      end
    end
  end

  // Entry that already carries the looked-up slave ID.
  // At most one entry can match, so the scan order does not affect the result.
  always_comb begin
    match_idx = '0;
    for (int i = MAX_UNIQ_IDS - 1; i >= 0; i--) begin
      if (match_vec[i]) begin
        match_idx = idx_t'(i);
      end
    end
  end

  assign lkp.full        = ~|free_vec;
  assign lkp.free_idx    = free_idx;
  assign lkp.exists      = |match_vec;
  assign lkp.exists_idx  = match_idx;
  // Only meaningful while exists is set.
  assign lkp.exists_full = (cnt_q[match_idx] == cnt_t'(MAX_TXNS_PER_ID));

  // Reverse lookup for the response path.
  assign pop_slv_id_o = id_q[pop_idx_i];

  // In-flight counters.
  // A push and a pop on the same entry in one cycle cancel out.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
        case ({push_hit[i], pop_hit[i]})
          2'b10:   cnt_q[i] <= cnt_q[i] + cnt_t'(1);
          2'b01:   cnt_q[i] <= cnt_q[i] - cnt_t'(1);
          default: cnt_q[i] <= cnt_q[i];
        endcase
      end
    end
  end

  // Slave IDs are written on every push.
  // A push to a busy entry rewrites the ID that the entry already holds.
  always_ff @(posedge clk_i) begin
    if (lkp.push) begin
      id_q[lkp.push_idx] <= lkp.push_slv_id;
    end
  end

  // The controller must only push to a free entry or to the entry owned by the same ID.
  // It must also respect the per-ID limit.
  a_push_target : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lkp.push |-> ((cnt_q[lkp.push_idx] == '0) || (id_q[lkp.push_idx] == lkp.push_slv_id))
                 && (cnt_q[lkp.push_idx] < cnt_t'(MAX_TXNS_PER_ID)));

  // A response must belong to a transaction that is actually in flight.
  a_pop_busy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> (cnt_q[pop_idx_i] != '0));

  // Each slave ID lives in at most one entry, otherwise ordering would break.
  a_unique_match : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(match_vec));

endmodule

`default_nettype wire

/* src/ax_id_assign.sv */
// Address-channel ID assignment.
// Admits AR or AW requests, picks a master ID from the remap table and holds stalled transfers.
`timescale 1ns/1ps
`default_nettype none

module ax_id_assign (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  slv_valid_i,
  input  id_remap_pkg::slv_id_t slv_id_i,
  output logic                  slv_ready_o,
  output logic                  mst_valid_o,
  output id_remap_pkg::mst_id_t mst_id_o,
  input  logic                  mst_ready_i,
  remap_table_if.ctrl           lkp
);
  import id_remap_pkg::*;

  // In Idle a request may be admitted; in Hold an admitted request waits for master ready.
  typedef enum logic {
    AX_IDLE,
    AX_HOLD
  } ax_state_e;

  ax_state_e state_q;
  ax_state_e state_d;
  idx_t      held_idx_q;
  idx_t      held_idx_d;

  logic admit;
  logic push;
  idx_t sel_idx;
  idx_t out_idx;

  // A request fits if its ID is in flight below the limit, or if it is new and room is left.
  assign admit = slv_valid_i &&
                 ((lkp.exists && !lkp.exists_full) || (!lkp.exists && !lkp.full));

  // Reusing the existing entry keeps same-ID transactions on one master ID, so order holds.
  assign sel_idx = lkp.exists ? lkp.exists_idx : lkp.free_idx;

  always_comb begin
    state_d     = state_q;
    held_idx_d  = held_idx_q;
    mst_valid_o = 1'b0;
    slv_ready_o = 1'b0;
    push        = 1'b0;
    out_idx     = sel_idx;

    case (state_q)
      AX_IDLE: begin
        if (admit) begin
          // The entry is claimed now, whether or not the master accepts this cycle.
          mst_valid_o = 1'b1;
          push        = 1'b1;
          slv_ready_o = mst_ready_i;
          if (!mst_ready_i) begin
            held_idx_d = sel_idx;
            state_d    = AX_HOLD;
          end
        end
      end

      AX_HOLD: begin
        // Already pushed, so only the registered ID is replayed here.
        mst_valid_o = 1'b1;
        out_idx     = held_idx_q;
        slv_ready_o = mst_ready_i;
        if (mst_ready_i) begin
          state_d = AX_IDLE;
        end
      end

      default: begin
        state_d = AX_IDLE;
      end
    endcase
  end

  // Lookup always follows the incoming ID; the table result is only used in Idle.
  assign lkp.lookup_id   = slv_id_i;
  assign lkp.push        = push;
  assign lkp.push_slv_id = slv_id_i;
  assign lkp.push_idx    = sel_idx;

  // Master IDs are the table index with zeros prepended.
  assign mst_id_o = {{(MST_ID_WIDTH - IDX_WIDTH){1'b0}}, out_idx};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= AX_IDLE;
      held_idx_q <= '0;
    end else begin
      state_q    <= state_d;
      held_idx_q <= held_idx_d;
    end
  end

  // A stalled request must not be withdrawn or change its ID before the master takes it.
  a_hold_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mst_valid_o && !mst_ready_i) |=> (mst_valid_o && $stable(mst_id_o)));

endmodule

`default_nettype wire

/* src/id_remap_top.sv */
// AXI ID remapper top level.
// Narrows AW and AR IDs through separate remap tables and restores B and R IDs.
`timescale 1ns/1ps
`default_nettype none

module id_remap_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Slave port.
  input  logic                  s_aw_valid_i,
  input  id_remap_pkg::slv_id_t s_aw_id_i,
  input  id_remap_pkg::addr_t   s_aw_addr_i,
  output logic                  s_aw_ready_o,
  output logic                  s_b_valid_o,
  output id_remap_pkg::slv_id_t s_b_id_o,
  output id_remap_pkg::resp_t   s_b_resp_o,
  input  logic                  s_b_ready_i,
  input  logic                  s_ar_valid_i,
  input  id_remap_pkg::slv_id_t s_ar_id_i,
  input  id_remap_pkg::addr_t   s_ar_addr_i,
  input  id_remap_pkg::len_t    s_ar_len_i,
  output logic                  s_ar_ready_o,
  output logic                  s_r_valid_o,
  output id_remap_pkg::slv_id_t s_r_id_o,
  output id_remap_pkg::data_t   s_r_data_o,
  output id_remap_pkg::resp_t   s_r_resp_o,
  output logic                  s_r_last_o,
  input  logic                  s_r_ready_i,

  // Master port.
  output logic                  m_aw_valid_o,
  output id_remap_pkg::mst_id_t m_aw_id_o,
  output id_remap_pkg::addr_t   m_aw_addr_o,
  input  logic                  m_aw_ready_i,
  input  logic                  m_b_valid_i,
  input  id_remap_pkg::mst_id_t m_b_id_i,
  input  id_remap_pkg::resp_t   m_b_resp_i,
  output logic                  m_b_ready_o,
  output logic                  m_ar_valid_o,
  output id_remap_pkg::mst_id_t m_ar_id_o,
  output id_remap_pkg::addr_t   m_ar_addr_o,
  output id_remap_pkg::len_t    m_ar_len_o,
  input  logic                  m_ar_ready_i,
  input  logic                  m_r_valid_i,
  input  id_remap_pkg::mst_id_t m_r_id_i,
  input  id_remap_pkg::data_t   m_r_data_i,
  input  id_remap_pkg::resp_t   m_r_resp_i,
  input  logic                  m_r_last_i,
  output logic                  m_r_ready_o
);
  import id_remap_pkg::*;

  remap_table_if i_wr_lkp ();
  remap_table_if i_rd_lkp ();

  logic wr_pop;
  logic rd_pop;

  // Address payload passes straight through; only IDs and handshakes are touched.
  assign m_aw_addr_o = s_aw_addr_i;
  assign m_ar_addr_o = s_ar_addr_i;
  assign m_ar_len_o  = s_ar_len_i;

  // Responses keep their timing; back-pressure goes straight to the master.
  assign s_b_valid_o = m_b_valid_i;
  assign s_b_resp_o  = m_b_resp_i;
  assign m_b_ready_o = s_b_ready_i;
  assign s_r_valid_o = m_r_valid_i;
  assign s_r_data_o  = m_r_data_i;
  assign s_r_resp_o  = m_r_resp_i;
  assign s_r_last_o  = m_r_last_i;
  assign m_r_ready_o = s_r_ready_i;

  // A write ends with its B beat; a read ends only with its last R beat.
  assign wr_pop = m_b_valid_i && s_b_ready_i;
  assign rd_pop = m_r_valid_i && s_r_ready_i && m_r_last_i;

  ax_id_assign i_aw_assign (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .slv_valid_i (s_aw_valid_i),
    .slv_id_i    (s_aw_id_i),
    .slv_ready_o (s_aw_ready_o),
    .mst_valid_o (m_aw_valid_o),
    .mst_id_o    (m_aw_id_o),
    .mst_ready_i (m_aw_ready_i),
    .lkp         (i_wr_lkp.ctrl)
  );

  id_remap_table i_wr_table (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .lkp          (i_wr_lkp.tbl),
    .pop_i        (wr_pop),
    .pop_idx_i    (m_b_id_i[IDX_WIDTH-1:0]),
    .pop_slv_id_o (s_b_id_o)
  );

  ax_id_assign i_ar_assign (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .slv_valid_i (s_ar_valid_i),
    .slv_id_i    (s_ar_id_i),
    .slv_ready_o (s_ar_ready_o),
    .mst_valid_o (m_ar_valid_o),
    .mst_id_o    (m_ar_id_o),
    .mst_ready_i (m_ar_ready_i),
    .lkp         (i_rd_lkp.ctrl)
  );

  id_remap_table i_rd_table (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .lkp          (i_rd_lkp.tbl),
    .pop_i        (rd_pop),
    .pop_idx_i    (m_r_id_i[IDX_WIDTH-1:0]),
    .pop_slv_id_o (s_r_id_o)
  );

endmodule

`default_nettype wire

/* verif/tb_id_remap.sv */
// Testbench for the AXI ID remapper.
// Drives the slave address channels, models the master side and checks the remapped IDs.
`timescale 1ns/1ps
`default_nettype none

module tb_id_remap;
  import id_remap_pkg::*;

  localparam int unsigned TIMEOUT = 50;

  logic    clk_i, rst_n_i;
  logic    s_aw_valid_i, s_aw_ready_o, s_b_valid_o, s_b_ready_i;
  logic    s_ar_valid_i, s_ar_ready_o, s_r_valid_o, s_r_last_o, s_r_ready_i;
  logic    m_aw_valid_o, m_aw_ready_i, m_b_valid_i, m_b_ready_o;
  logic    m_ar_valid_o, m_ar_ready_i, m_r_valid_i, m_r_last_i, m_r_ready_o;
  slv_id_t s_aw_id_i, s_b_id_o, s_ar_id_i, s_r_id_o;
  mst_id_t m_aw_id_o, m_b_id_i, m_ar_id_o, m_r_id_i;
  addr_t   s_aw_addr_i, s_ar_addr_i, m_aw_addr_o, m_ar_addr_o;
  len_t    s_ar_len_i, m_ar_len_o;
  data_t   s_r_data_o, m_r_data_i;
  resp_t   s_b_resp_o, m_b_resp_i, s_r_resp_o, m_r_resp_i;

  int      errors;
  int      checks;
  integer  seed;
  // Outstanding master IDs seen by the master model, oldest first.
  mst_id_t rd_q[$];
  mst_id_t wr_q[$];
  // Slave ID that the stimulus sent for each master ID, used to check the restored IDs.
  slv_id_t rd_owner[MAX_UNIQ_IDS];
  slv_id_t wr_owner[MAX_UNIQ_IDS];

  id_remap_top i_id_remap_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Every accepted address beat becomes an outstanding transaction of the master model.
  always @(negedge clk_i) begin
    if (rst_n_i && m_ar_valid_o && m_ar_ready_i) begin
      rd_q.push_back(m_ar_id_o);
    end
    if (rst_n_i && m_aw_valid_o && m_aw_ready_i) begin
      wr_q.push_back(m_aw_id_o);
    end
  end

  // A stalled address beat keeps its valid and its master ID.
  a_ar_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (m_ar_valid_o && !m_ar_ready_i) |=> (m_ar_valid_o && $stable(m_ar_id_o)))
    else begin
      errors++;
      $display("ERROR: AR master valid or ID changed while the master stalled");
    end
  a_aw_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (m_aw_valid_o && !m_aw_ready_i) |=> (m_aw_valid_o && $stable(m_aw_id_o)))
    else begin
      errors++;
      $display("ERROR: AW master valid or ID changed while the master stalled");
    end

  // Nothing leaves on the master side unless the slave asked for it.
  a_quiet : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (s_ar_valid_i || !m_ar_valid_o) && (s_aw_valid_i || !m_aw_valid_o))
    else begin
      errors++;
      $display("ERROR: master address valid raised without a slave request");
    end

  // Payload, response codes and response handshakes go through untouched.
  a_passthrough : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (s_r_valid_o == m_r_valid_i) && (s_r_data_o == m_r_data_i) && (s_r_resp_o == m_r_resp_i)
    && (s_r_last_o == m_r_last_i) && (m_r_ready_o == s_r_ready_i)
    && (s_b_valid_o == m_b_valid_i) && (s_b_resp_o == m_b_resp_i) && (m_b_ready_o == s_b_ready_i)
    && (m_aw_addr_o == s_aw_addr_i) && (m_ar_addr_o == s_ar_addr_i) && (m_ar_len_o == s_ar_len_i))
    else begin
      errors++;
      $display("ERROR: payload or response handshake was altered on its way through");
    end

  task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic note_timeout(input string what);
    errors++;
    $display("ERROR: timed out waiting for %s", what);
  endtask

  function automatic logic random_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  task automatic start_ar(input slv_id_t id);
    @(posedge clk_i);
    #1;
    s_ar_valid_i = 1'b1;
    s_ar_id_i    = id;
    s_ar_addr_i  = $random(seed);
    s_ar_len_i   = len_t'($random(seed));
  endtask

  task automatic start_aw(input slv_id_t id);
    @(posedge clk_i);
    #1;
    s_aw_valid_i = 1'b1;
    s_aw_id_i    = id;
    s_aw_addr_i  = $random(seed);
  endtask

  // Waits for the slave-side handshake, then checks the forwarded beat.
  task automatic finish_ar(input mst_id_t exp_id, input string name);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (!s_ar_ready_o && n < TIMEOUT) begin
      n++;
      @(negedge clk_i);
    end
    if (!s_ar_ready_o) begin
      note_timeout({name, " AR ready"});
    end else begin
      compare_value({name, " AR id"}, 32'(exp_id), 32'(m_ar_id_o));
      compare_value({name, " AR addr"}, s_ar_addr_i, m_ar_addr_o);
      compare_value({name, " AR len"}, 32'(s_ar_len_i), 32'(m_ar_len_o));
      rd_owner[exp_id[IDX_WIDTH-1:0]] = s_ar_id_i;
    end
    @(posedge clk_i);
    #1;
    s_ar_valid_i = 1'b0;
  endtask

  task automatic finish_aw(input mst_id_t exp_id, input string name);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (!s_aw_ready_o && n < TIMEOUT) begin
      n++;
      @(negedge clk_i);
    end
    if (!s_aw_ready_o) begin
      note_timeout({name, " AW ready"});
    end else begin
      compare_value({name, " AW id"}, 32'(exp_id), 32'(m_aw_id_o));
      compare_value({name, " AW addr"}, s_aw_addr_i, m_aw_addr_o);
      wr_owner[exp_id[IDX_WIDTH-1:0]] = s_aw_id_i;
    end
    @(posedge clk_i);
    #1;
    s_aw_valid_i = 1'b0;
  endtask

  // A pending request must see neither slave ready nor master valid.
  task automatic expect_stall(input bit is_write, input int unsigned cycles, input string name);
    repeat (cycles) begin
      @(negedge clk_i);
      compare_value({name, " slave ready"}, 32'd0,
                    is_write ? 32'(s_aw_ready_o) : 32'(s_ar_ready_o));
      compare_value({name, " master valid"}, 32'd0,
                    is_write ? 32'(m_aw_valid_o) : 32'(m_ar_valid_o));
    end
  endtask

  // Keeps master ready low for a few cycles and watches the held beat, then releases it.
  task automatic check_hold(input bit is_write, input mst_id_t exp_id, input string name);
    int unsigned stall;
    stall = 2 + ($unsigned($random(seed)) % 4);
    repeat (stall) begin
      @(negedge clk_i);
      compare_value({name, " valid"}, 32'd1, is_write ? 32'(m_aw_valid_o) : 32'(m_ar_valid_o));
      compare_value({name, " id"}, 32'(exp_id), is_write ? 32'(m_aw_id_o) : 32'(m_ar_id_o));
    end
    @(posedge clk_i);
    #1;
    m_aw_ready_i = 1'b1;
    m_ar_ready_i = 1'b1;
  endtask

  // Master model answers its oldest outstanding transaction after a random gap.
  // The slave side accepts with a random ready.
  task automatic respond(input bit is_write, input logic last, input string name);
    int unsigned n;
    int unsigned gap;
    mst_id_t     id;
    data_t       data;
    resp_t       resp;
    if ((is_write ? wr_q.size() : rd_q.size()) == 0) begin
      errors++;
      $display("ERROR: %s found no outstanding transaction to answer", name);
      return;
    end
    id   = is_write ? wr_q[0] : rd_q[0];
    data = $random(seed);
    resp = resp_t'($random(seed));
    gap  = $unsigned($random(seed)) % 3;
    repeat (gap) @(posedge clk_i);
    @(posedge clk_i);
    #1;
    if (is_write) begin
      m_b_valid_i = 1'b1;
      m_b_id_i    = id;
      m_b_resp_i  = resp;
    end else begin
      m_r_valid_i = 1'b1;
      m_r_id_i    = id;
      m_r_data_i  = data;
      m_r_resp_i  = resp;
      m_r_last_i  = last;
    end
    s_b_ready_i = random_bit();
    s_r_ready_i = random_bit();
    n = 0;
    @(negedge clk_i);
    while (!(is_write ? m_b_ready_o : m_r_ready_o) && n < TIMEOUT) begin
      n++;
      @(posedge clk_i);
      #1;
      s_b_ready_i = random_bit();
      s_r_ready_i = random_bit();
      @(negedge clk_i);
    end
    if (!(is_write ? m_b_ready_o : m_r_ready_o)) begin
      note_timeout({name, " response ready"});
    end else if (is_write) begin
      compare_value({name, " B id"}, 32'(wr_owner[id[IDX_WIDTH-1:0]]), 32'(s_b_id_o));
      compare_value({name, " B resp"}, 32'(resp), 32'(s_b_resp_o));
      void'(wr_q.pop_front());
    end else begin
      compare_value({name, " R id"}, 32'(rd_owner[id[IDX_WIDTH-1:0]]), 32'(s_r_id_o));
      compare_value({name, " R data"}, data, s_r_data_o);
      compare_value({name, " R resp"}, 32'(resp), 32'(s_r_resp_o));
      compare_value({name, " R last"}, 32'(last), 32'(s_r_last_o));
      if (last) begin
        void'(rd_q.pop_front());
      end
    end
    @(posedge clk_i);
    #1;
    m_b_valid_i = 1'b0;
    m_r_valid_i = 1'b0;
    m_r_last_i  = 1'b0;
    s_b_ready_i = 1'b1;
    s_r_ready_i = 1'b1;
  endtask

  initial begin
    seed         = 32'h4f6e5eee;
    errors       = 0;
    checks       = 0;
    rst_n_i      = 1'b0;
    s_aw_valid_i = 1'b0;
    s_aw_id_i    = '0;
    s_aw_addr_i  = '0;
    s_b_ready_i  = 1'b1;
    s_ar_valid_i = 1'b0;
    s_ar_id_i    = '0;
    s_ar_addr_i  = '0;
    s_ar_len_i   = '0;
    s_r_ready_i  = 1'b1;
    m_aw_ready_i = 1'b1;
    m_b_valid_i  = 1'b0;
    m_b_id_i     = '0;
    m_b_resp_i   = '0;
    m_ar_ready_i = 1'b1;
    m_r_valid_i  = 1'b0;
    m_r_id_i     = '0;
    m_r_data_i   = '0;
    m_r_resp_i   = '0;
    m_r_last_i   = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    expect_stall(1'b0, 2, "reset_ar");
    expect_stall(1'b1, 1, "reset_aw");

    // Four distinct read IDs fill the table from entry 0 upward.
    for (int i = 0; i < 4; i++) begin
      start_ar(slv_id_t'(8'h11 * (i + 1)));
      finish_ar(mst_id_t'(i), "lowest_free");
    end
    repeat (2) begin
      start_ar(8'h22);
      finish_ar(3'd1, "ar_reuse");
    end

    // A fifth ID waits in the full table; only the last beat of 0x11 frees entry 0.
    start_ar(8'h55);
    expect_stall(1'b0, 4, "table_full");
    respond(1'b0, 1'b0, "r_not_last");
    expect_stall(1'b0, 3, "r_not_last_stall");
    respond(1'b0, 1'b1, "r_last");
    finish_ar(3'd0, "table_full_free");

    // Three writes of 0x77 share entry 0, and a fourth hits the per-ID limit.
    repeat (3) begin
      start_aw(8'h77);
      finish_aw(3'd0, "aw_reuse");
    end
    start_aw(8'h77);
    expect_stall(1'b1, 4, "per_id_limit");
    respond(1'b1, 1'b1, "b_restore");
    finish_aw(3'd0, "per_id_free");
    start_aw(8'h90);
    finish_aw(3'd1, "aw_new_id");

    for (int i = 0; i < 16 && rd_q.size() > 0; i++) begin
      respond(1'b0, 1'b1, "r_drain");
    end
    for (int i = 0; i < 16 && wr_q.size() > 0; i++) begin
      respond(1'b1, 1'b1, "b_drain");
    end

    // With the tables empty again, stalled beats land on entry 0 and must hold still.
    m_ar_ready_i = 1'b0;
    start_ar(8'h66);
    check_hold(1'b0, 3'd0, "ar_hold");
    finish_ar(3'd0, "ar_hold_done");
    m_aw_ready_i = 1'b0;
    start_aw(8'hab);
    check_hold(1'b1, 3'd0, "aw_hold");
    finish_aw(3'd0, "aw_hold_done");
    respond(1'b0, 1'b1, "r_final");
    respond(1'b1, 1'b1, "b_final");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* id_remap.f */
src/id_remap_pkg.sv
src/remap_table_if.sv
src/id_remap_table.sv
src/ax_id_assign.sv
src/id_remap_top.sv
verif/tb_id_remap.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the ID remapper testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_id_remap

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -f id_remap.f
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

# The log decides the result.
if grep -qx "Verification passed" "$LOG_FILE"; then
  echo "RESULT: PASS"
  exit 0
fi
echo "RESULT: FAIL"
exit 1
